//--- event_dispatch.sv
/* One event per cycle with no back-pressure. Invalid cycles and the unused
   kind code produce no strobe; strobes appear one cycle after the event. */
`include "stats_macros.svh"

module event_dispatch (
   input  logic                                        ACLK,
   input  logic                                        ARESETN,
   input  stats_pkg::port_event_t                      evt,
   output stats_pkg::port_inc_t [`STATS_NUM_PORTS-1:0] inc
);

   localparam int unsigned NP    = `STATS_NUM_PORTS;
   localparam int unsigned IDX_W = `STATS_PORT_IDX_W;

   // Event as sampled on the last edge
   stats_pkg::port_event_t evt_q;

   //////////////////////////////
   // Input register

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         evt_q <= '0;
      end else begin
         evt_q <= evt;
      end
   end

   //////////////////////////////
   // Port and kind decode

   always_comb begin
      for (int p = 0; p < NP; p++) begin
         inc[p] = '0;
         // Only the addressed port sees a strobe
         if (evt_q.valid && (evt_q.port == IDX_W'(p))) begin
            inc[p].tx  = (evt_q.kind == stats_pkg::EV_TX);
            inc[p].rx  = (evt_q.kind == stats_pkg::EV_RX);
            inc[p].err = (evt_q.kind == stats_pkg::EV_ERR);
         end
      end
   end

endmodule

//--- port_counters.sv
/* Counters wrap at 2**STATS_CNT_W with no saturation flag.
   A clear on the same edge as an increment leaves the counter at zero. */
`include "stats_macros.svh"

module port_counters (
   input  logic                 ACLK,
   input  logic                 ARESETN,
   input  stats_pkg::port_inc_t inc,
   input  logic                 clear,
   output stats_pkg::port_cnt_t cnt
);

   stats_pkg::port_cnt_t cnt_next;

   // Next value of one counter, clear first
   function automatic logic [`STATS_CNT_W-1:0] next_count(
      input logic [`STATS_CNT_W-1:0] cur,
      input logic                    bump,
      input logic                    zero
   );
      logic [`STATS_CNT_W-1:0] nxt;
      nxt = cur;
      if (zero) begin
         nxt = '0;
      end else if (bump) begin
         nxt = cur + 1'b1;
      end
      return nxt;
   endfunction

   //////////////////////////////
   // Counter update

   always_comb begin
      cnt_next.tx  = next_count(cnt.tx, inc.tx, clear);
      cnt_next.rx  = next_count(cnt.rx, inc.rx, clear);
      cnt_next.err = next_count(cnt.err, inc.err, clear);
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         cnt <= '0;
      end else begin
         cnt <= cnt_next;
      end
   end

endmodule

//--- port_stats_top.f
+incdir+.
stats_pkg.sv
event_dispatch.sv
port_counters.sv
stats_axil_regs.sv
port_stats_top.sv
tb_port_stats.sv

//--- port_stats_top.sv
/* Everything runs on ACLK. Counts are readable one edge after the dispatcher
   registers an event; a clear takes effect on the edge after the write is taken. */
`include "stats_macros.svh"

module port_stats_top (
   input  logic                           ACLK,
   input  logic                           ARESETN,

   // Traffic events, always accepted
   input  stats_pkg::port_event_t         evt,

   input  logic [`STATS_AXI_ADDR_W-1:0]   AWADDR,
   input  logic                           AWVALID,
   output logic                           AWREADY,
   input  logic [`STATS_AXI_DATA_W-1:0]   WDATA,
   input  logic [`STATS_AXI_DATA_W/8-1:0] WSTRB,
   input  logic                           WVALID,
   output logic                           WREADY,
   output stats_pkg::axi_resp_e           BRESP,
   output logic                           BVALID,
   input  logic                           BREADY,
   input  logic [`STATS_AXI_ADDR_W-1:0]   ARADDR,
   input  logic                           ARVALID,
   output logic                           ARREADY,
   output logic [`STATS_AXI_DATA_W-1:0]   RDATA,
   output stats_pkg::axi_resp_e           RRESP,
   output logic                           RVALID,
   input  logic                           RREADY
);

   stats_pkg::port_inc_t [`STATS_NUM_PORTS-1:0] inc;
   stats_pkg::port_cnt_t [`STATS_NUM_PORTS-1:0] cnt;
   logic [`STATS_NUM_PORTS-1:0]                 clear;

   event_dispatch i_dispatch (
      .ACLK    (ACLK),
      .ARESETN (ARESETN),
      .evt     (evt),
      .inc     (inc)
   );

   // One counter bank per switch port
   for (genvar p = 0; p < `STATS_NUM_PORTS; p++) begin : g_port
      port_counters i_counters (
         .ACLK    (ACLK),
         .ARESETN (ARESETN),
         .inc     (inc[p]),
         .clear   (clear[p]),
         .cnt     (cnt[p])
      );
   end

   stats_axil_regs i_regs (
      .ACLK    (ACLK),
      .ARESETN (ARESETN),
      .AWADDR  (AWADDR),
      .AWVALID (AWVALID),
      .AWREADY (AWREADY),
      .WDATA   (WDATA),
      .WSTRB   (WSTRB),
      .WVALID  (WVALID),
      .WREADY  (WREADY),
      .BRESP   (BRESP),
      .BVALID  (BVALID),
      .BREADY  (BREADY),
      .ARADDR  (ARADDR),
      .ARVALID (ARVALID),
      .ARREADY (ARREADY),
      .RDATA   (RDATA),
      .RRESP   (RRESP),
      .RVALID  (RVALID),
      .RREADY  (RREADY),
      .cnt     (cnt),
      .clear   (clear)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds and runs the port statistics testbench with Verilator.
# Exits with a nonzero status if the build, the run or any check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/100ps \
   --top-module tb_port_stats -f port_stats_top.f \
   -Mdir "$OBJ" -o Vtb_port_stats
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/Vtb_port_stats" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
   echo "Simulation reported failures, see $LOG"
   exit 1
fi

exit 0

//--- stats_axil_regs.sv
/* One read and one write outstanding; a write is taken only when AWVALID and
   WVALID are both high. The only accepted write is a clear to a port's REG_CLEAR. */
`include "stats_macros.svh"

module stats_axil_regs (
   input  logic                                        ACLK,
   input  logic                                        ARESETN,

   input  logic [`STATS_AXI_ADDR_W-1:0]                AWADDR,
   input  logic                                        AWVALID,
   output logic                                        AWREADY,

   input  logic [`STATS_AXI_DATA_W-1:0]                WDATA,
   input  logic [`STATS_AXI_DATA_W/8-1:0]              WSTRB,
   input  logic                                        WVALID,
   output logic                                        WREADY,

   output stats_pkg::axi_resp_e                        BRESP,
   output logic                                        BVALID,
   input  logic                                        BREADY,

   input  logic [`STATS_AXI_ADDR_W-1:0]                ARADDR,
   input  logic                                        ARVALID,
   output logic                                        ARREADY,

   output logic [`STATS_AXI_DATA_W-1:0]                RDATA,
   output stats_pkg::axi_resp_e                        RRESP,
   output logic                                        RVALID,
   input  logic                                        RREADY,

   input  stats_pkg::port_cnt_t [`STATS_NUM_PORTS-1:0] cnt,
   output logic [`STATS_NUM_PORTS-1:0]                 clear
);

   localparam int unsigned AW    = `STATS_AXI_ADDR_W;
   localparam int unsigned DW    = `STATS_AXI_DATA_W;
   localparam int unsigned NP    = `STATS_NUM_PORTS;
   localparam int unsigned IDX_W = `STATS_PORT_IDX_W;

   stats_pkg::rd_state_e rd_state;
   stats_pkg::wr_state_e wr_state;

   // Read address fields
   logic [IDX_W-1:0]     ar_port;
   stats_pkg::stat_reg_e ar_reg;
   logic                 ar_in_map;
   logic                 ar_fire;
   logic [DW-1:0]        rd_data_d;
   stats_pkg::axi_resp_e rd_resp_d;

   // Write address fields
   logic [IDX_W-1:0]     aw_port;
   logic                 aw_is_clear;
   logic                 wr_fire;
   logic                 wr_ok;

   //////////////////////////////
   // Read channel

   assign ar_port   = ARADDR[4 +: IDX_W];
   assign ar_reg    = stats_pkg::stat_reg_e'(ARADDR[3:2]);
   assign ar_in_map = (ARADDR[AW-1:6] == '0);

   assign ARREADY = (rd_state == stats_pkg::RD_IDLE);
   assign RVALID  = (rd_state == stats_pkg::RD_RESP);
   assign ar_fire = ARVALID && ARREADY;

   // Counter select, SLVERR for REG_CLEAR and the upper address space
   always_comb begin
      rd_data_d = '0;
      rd_resp_d = stats_pkg::RESP_SLVERR;
      if (ar_in_map) begin
         case (ar_reg)
            stats_pkg::REG_TX: begin
               rd_data_d = DW'(cnt[ar_port].tx);
               rd_resp_d = stats_pkg::RESP_OKAY;
            end
            stats_pkg::REG_RX: begin
               rd_data_d = DW'(cnt[ar_port].rx);
               rd_resp_d = stats_pkg::RESP_OKAY;
            end
            stats_pkg::REG_ERR: begin
               rd_data_d = DW'(cnt[ar_port].err);
               rd_resp_d = stats_pkg::RESP_OKAY;
            end
            default: begin
               rd_data_d = '0;
            end
         endcase
      end
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         rd_state <= stats_pkg::RD_IDLE;
      end else begin
         case (rd_state)
            stats_pkg::RD_IDLE: begin
               if (ARVALID) begin
                  rd_state <= stats_pkg::RD_RESP;
               end
            end
            default: begin
               if (RREADY) begin
                  rd_state <= stats_pkg::RD_IDLE;
               end
            end
         endcase
      end
   end

   // Held stable until the R handshake
   always_ff @(posedge ACLK) begin
      if (ar_fire) begin
         RDATA <= rd_data_d;
         RRESP <= rd_resp_d;
      end
   end

   //////////////////////////////
   // Write channel

   assign aw_port     = AWADDR[4 +: IDX_W];
   assign aw_is_clear = (AWADDR[AW-1:6] == '0) &&
                        (stats_pkg::stat_reg_e'(AWADDR[3:2]) == stats_pkg::REG_CLEAR);

   assign AWREADY = (wr_state == stats_pkg::WR_IDLE);
   assign WREADY  = (wr_state == stats_pkg::WR_IDLE);
   assign BVALID  = (wr_state == stats_pkg::WR_RESP);

   // Both halves must be present in the same cycle
   assign wr_fire = AWVALID && WVALID && AWREADY;
   assign wr_ok   = aw_is_clear && WSTRB[0] && WDATA[0];

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         wr_state <= stats_pkg::WR_IDLE;
         clear    <= '0;
      end else begin
         clear <= '0;
         case (wr_state)
            stats_pkg::WR_IDLE: begin
               if (wr_fire) begin
                  wr_state <= stats_pkg::WR_RESP;
                  if (wr_ok) begin
                     clear <= NP'(1) << aw_port;
                  end
               end
            end
            default: begin
               if (BREADY) begin
                  wr_state <= stats_pkg::WR_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge ACLK) begin
      if (wr_fire) begin
         BRESP <= wr_ok ? stats_pkg::RESP_OKAY : stats_pkg::RESP_SLVERR;
      end
   end

endmodule

//--- stats_macros.svh
/* Sizes for the port statistics block. The address map assumes 16-byte port windows
   and STATS_AXI_ADDR_W >= 7, with STATS_CNT_W no wider than STATS_AXI_DATA_W. */
`ifndef STATS_MACROS_SVH
`define STATS_MACROS_SVH

// Switch ports and the width of a port index
`define STATS_NUM_PORTS   4
`define STATS_PORT_IDX_W  2

// Width of each wrapping counter
`define STATS_CNT_W       32

// AXI4-Lite register slave
`define STATS_AXI_ADDR_W  8
`define STATS_AXI_DATA_W  32

`endif

//--- stats_pkg.sv
/* Types shared by the statistics RTL and its testbench.
   Widths come from the macro header, so both must be compiled together. */
`include "stats_macros.svh"

package stats_pkg;

   //////////////////////////////
   // Event bus

   // Code 2'b11 is unused and counts nothing
   typedef enum logic [1:0] {
      EV_TX  = 2'd0,
      EV_RX  = 2'd1,
      EV_ERR = 2'd2
   } event_kind_e;

   typedef struct packed {
      logic                         valid;
      logic [`STATS_PORT_IDX_W-1:0] port;
      event_kind_e                  kind;
   } port_event_t;

   //////////////////////////////
   // Per-port counter interface

   // One strobe per counter, at most one set per cycle
   typedef struct packed {
      logic tx;
      logic rx;
      logic err;
   } port_inc_t;

   typedef struct packed {
      logic [`STATS_CNT_W-1:0] tx;
      logic [`STATS_CNT_W-1:0] rx;
      logic [`STATS_CNT_W-1:0] err;
   } port_cnt_t;

   //////////////////////////////
   // Register slave

   // Word index inside a port's 16-byte window
   typedef enum logic [1:0] {
      REG_TX    = 2'd0,
      REG_RX    = 2'd1,
      REG_ERR   = 2'd2,
      REG_CLEAR = 2'd3
   } stat_reg_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

   typedef enum logic {RD_IDLE, RD_RESP} rd_state_e;
   typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;

endpackage

//--- tb_port_stats.sv
/* Self-checking testbench for port_stats_top. Expected values come from a cycle
   model of the counters kept in the testbench; a watchdog bounds the run. */
`include "stats_macros.svh"

module tb_port_stats;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NP              = `STATS_NUM_PORTS;
   localparam int IDX_W           = `STATS_PORT_IDX_W;
   localparam int AW              = `STATS_AXI_ADDR_W;
   localparam int DW              = `STATS_AXI_DATA_W;
   localparam int CLK_PERIOD      = 4;
   // Events in tests 2 and 5, and an upper bound on bus transactions
   localparam int NUM_EVENTS      = 550;
   localparam int NUM_XACT        = 120;
   localparam int CYCLES_PER_ITEM = 24;
   localparam int WATCHDOG_NS     = (NUM_EVENTS + NUM_XACT) * CYCLES_PER_ITEM * CLK_PERIOD;

   typedef struct packed {
      logic [AW-1:0] addr;
      logic [DW-1:0] data;
      logic [1:0]    resp;
   } rd_exp_t;

   logic                   ACLK = 1'b0;
   logic                   ARESETN;
   stats_pkg::port_event_t evt;
   logic [AW-1:0]          AWADDR, ARADDR;
   logic [DW-1:0]          WDATA, RDATA;
   logic [DW/8-1:0]        WSTRB;
   logic                   AWVALID, AWREADY, WVALID, WREADY, BVALID, BREADY;
   logic                   ARVALID, ARREADY, RVALID, RREADY;
   stats_pkg::axi_resp_e   BRESP, RRESP;

   // Modelled counters and the pipeline stages in front of them
   stats_pkg::port_cnt_t   model_cnt [NP];
   stats_pkg::port_event_t ev_pipe;
   logic                   clr_pend;
   logic [IDX_W-1:0]       clr_port;
   rd_exp_t                rd_exp_q[$];
   logic [1:0]             wr_exp_q[$];
   stats_pkg::port_event_t ev_stim_q[$];

   // Response values seen while the master stalls
   logic                   r_held, b_held;
   logic [DW-1:0]          r_held_data;
   logic [1:0]             r_held_resp, b_held_resp;

   logic [31:0]            lcg_state = 32'd45;
   int                     errors = 0;
   int                     checks = 0;

   port_stats_top i_dut (.*);

   always #(CLK_PERIOD / 2) ACLK = ~ACLK;

   //////////////////////////////
   // Helpers and reference model

   function automatic logic [31:0] rand_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [AW-1:0] make_addr(input logic [IDX_W-1:0] port,
                                               input logic [1:0] idx);
      return AW'({port, idx, 2'b00});
   endfunction

   // Expected read result from the address map
   function automatic rd_exp_t ref_read(input logic [AW-1:0] addr);
      rd_exp_t          res;
      logic [IDX_W-1:0] p;
      p        = addr[4 +: IDX_W];
      res.addr = addr;
      res.data = '0;
      res.resp = stats_pkg::RESP_SLVERR;
      if (addr[AW-1:6] == '0) begin
         case (addr[3:2])
            2'd0: res.data = model_cnt[p].tx;
            2'd1: res.data = model_cnt[p].rx;
            2'd2: res.data = model_cnt[p].err;
            default: begin
            end
         endcase
         if (addr[3:2] != 2'd3) begin
            res.resp = stats_pkg::RESP_OKAY;
         end
      end
      return res;
   endfunction

   function automatic logic ref_write_ok(input logic [AW-1:0] addr,
                                         input logic [DW-1:0] data,
                                         input logic [DW/8-1:0] strb);
      return (addr[AW-1:6] == '0) && (addr[3:2] == 2'd3) && strb[0] && data[0];
   endfunction

   task automatic check_value(input logic [DW-1:0] actual, input logic [DW-1:0] expected,
                              input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Error at time %0t: %s, got 0x%08h, expected 0x%08h",
                  $time, what, actual, expected);
      end
   endtask

   task automatic report_test(input int num, input string name, input int err_start);
      $display("Test %0d %s: %0d errors", num, name, errors - err_start);
   endtask

   //////////////////////////////
   // Model and response checking

   // Counts change two edges after the event is driven and one edge after a clear write
   always @(posedge ACLK) begin : model_update
      logic             take_clear;
      logic [IDX_W-1:0] take_port;
      if (!ARESETN) begin
         for (int p = 0; p < NP; p++) begin
            model_cnt[p] = '0;
         end
         ev_pipe  = '0;
         clr_pend = 1'b0;
         clr_port = '0;
      end else begin
         take_clear = 1'b0;
         take_port  = AWADDR[4 +: IDX_W];
         // Read data is captured before this edge's update
         if (ARVALID && ARREADY) begin
            rd_exp_q.push_back(ref_read(ARADDR));
         end
         if (AWVALID && WVALID && AWREADY && WREADY) begin
            take_clear = ref_write_ok(AWADDR, WDATA, WSTRB);
            wr_exp_q.push_back(take_clear ? stats_pkg::RESP_OKAY : stats_pkg::RESP_SLVERR);
         end
         if (ev_pipe.valid) begin
            case (ev_pipe.kind)
               stats_pkg::EV_TX:  model_cnt[ev_pipe.port].tx  = model_cnt[ev_pipe.port].tx + 1'b1;
               stats_pkg::EV_RX:  model_cnt[ev_pipe.port].rx  = model_cnt[ev_pipe.port].rx + 1'b1;
               stats_pkg::EV_ERR: model_cnt[ev_pipe.port].err = model_cnt[ev_pipe.port].err + 1'b1;
               default: begin
               end
            endcase
         end
         // Clear wins over an increment on the same edge
         if (clr_pend) begin
            model_cnt[clr_port] = '0;
         end
         ev_pipe  = evt;
         clr_pend = take_clear;
         clr_port = take_port;
      end
   end

   always @(posedge ACLK) begin : beat_check
      rd_exp_t    exp_r;
      logic [1:0] exp_b;
      if (!ARESETN) begin
         r_held = 1'b0;
         b_held = 1'b0;
      end else begin
         if (RVALID) begin
            check_value(DW'(ARREADY), '0, "ARREADY while a read response is pending");
         end
         if (BVALID) begin
            check_value(DW'({AWREADY, WREADY}), '0,
                        "AWREADY and WREADY while a write response is pending");
         end
         if (r_held) begin
            check_value(RDATA, r_held_data, "RDATA held while RREADY low");
            check_value(DW'(RRESP), DW'(r_held_resp), "RRESP held while RREADY low");
         end
         if (RVALID && RREADY) begin
            if (rd_exp_q.size() == 0) begin
               errors++;
               $display("A read response arrived with no read outstanding");
            end else begin
               exp_r = rd_exp_q.pop_front();
               check_value(RDATA, exp_r.data, $sformatf("RDATA of 0x%02h", exp_r.addr));
               check_value(DW'(RRESP), DW'(exp_r.resp), $sformatf("RRESP of 0x%02h", exp_r.addr));
            end
         end
         if (b_held) begin
            check_value(DW'(BRESP), DW'(b_held_resp), "BRESP held while BREADY low");
         end
         if (BVALID && BREADY) begin
            if (wr_exp_q.size() == 0) begin
               errors++;
               $display("A write response arrived with no write outstanding");
            end else begin
               exp_b = wr_exp_q.pop_front();
               check_value(DW'(BRESP), DW'(exp_b), "BRESP against the address map");
            end
         end
         r_held      = RVALID && !RREADY;
         r_held_data = RDATA;
         r_held_resp = RRESP;
         b_held      = BVALID && !BREADY;
         b_held_resp = BRESP;
      end
   end

   //////////////////////////////
   // Stimulus tasks

   // Idle cycles, invalid cycles with junk fields and valid events of all four kind codes
   task automatic fill_events(input int n);
      logic [31:0]            r;
      stats_pkg::port_event_t e;
      repeat (n) begin
         r       = rand_next();
         e.valid = (r[31:28] > 4'd1);
         e.port  = IDX_W'(r[23:20]);
         e.kind  = stats_pkg::event_kind_e'(r[17:16]);
         if (r[31:28] == 4'd0) begin
            e = '0;
         end
         ev_stim_q.push_back(e);
      end
   endtask

   task automatic play_events();
      stats_pkg::port_event_t e;
      while (ev_stim_q.size() > 0) begin
         e = ev_stim_q.pop_front();
         @(negedge ACLK);
         evt = e;
      end
      @(negedge ACLK);
      evt = '0;
   endtask

   task automatic start_read(input logic [AW-1:0] addr);
      @(negedge ACLK);
      ARADDR  = addr;
      ARVALID = 1'b1;
      RREADY  = 1'b0;
      @(posedge ACLK);
      while (!ARREADY) @(posedge ACLK);
   endtask

   // Stall RREADY and optionally keep the next request on AR
   task automatic finish_read(input int hold, input logic keep_ar, input logic [AW-1:0] next);
      @(negedge ACLK);
      ARVALID = keep_ar;
      ARADDR  = next;
      repeat (hold) @(negedge ACLK);
      RREADY = 1'b1;
      @(posedge ACLK);
      while (!RVALID) @(posedge ACLK);
      @(negedge ACLK);
      RREADY = 1'b0;
   endtask

   task automatic do_read(input logic [AW-1:0] addr, input int hold);
      start_read(addr);
      finish_read(hold, 1'b0, '0);
   endtask

   task automatic read_all(input logic hold_rand);
      for (int p = 0; p < NP; p++) begin
         for (int k = 0; k < 3; k++) begin
            do_read(make_addr(IDX_W'(p), 2'(k)), hold_rand ? int'(rand_next() % 32'd8) : 0);
         end
      end
   endtask

   task automatic do_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                           input logic [DW/8-1:0] strb, input int aw_delay,
                           input int w_delay, input int hold);
      int   cyc;
      logic accepted;
      cyc      = 0;
      accepted = 1'b0;
      while (!accepted) begin
         @(negedge ACLK);
         AWADDR  = addr;
         WDATA   = data;
         WSTRB   = strb;
         BREADY  = 1'b0;
         AWVALID = (cyc >= aw_delay);
         WVALID  = (cyc >= w_delay);
         @(posedge ACLK);
         accepted = AWVALID && WVALID && AWREADY && WREADY;
         cyc++;
      end
      @(negedge ACLK);
      AWVALID = 1'b0;
      WVALID  = 1'b0;
      repeat (hold) @(negedge ACLK);
      BREADY = 1'b1;
      @(posedge ACLK);
      while (!BVALID) @(posedge ACLK);
      @(negedge ACLK);
      BREADY = 1'b0;
   endtask

   //////////////////////////////
   // Test sequence

   initial begin : main
      int               err_start;
      int               hold_a [8];
      logic [AW-1:0]    addr_a [8];
      logic [AW-1:0]    a;
      logic [IDX_W-1:0] cp;
      logic             left_over;
      ARESETN = 1'b0;
      evt     = '0;
      AWADDR  = '0;
      AWVALID = 1'b0;
      WDATA   = '0;
      WSTRB   = '0;
      WVALID  = 1'b0;
      BREADY  = 1'b0;
      ARADDR  = '0;
      ARVALID = 1'b0;
      RREADY  = 1'b0;
      repeat (2) @(negedge ACLK);
      ARESETN = 1'b1;

      err_start = errors;
      read_all(1'b0);
      report_test(1, "counts after reset", err_start);

      err_start = errors;
      fill_events(400);
      play_events();
      repeat (2) @(negedge ACLK);
      read_all(1'b0);
      report_test(2, "random event stream", err_start);

      err_start = errors;
      for (int p = 0; p < NP; p++) begin
         do_read(make_addr(IDX_W'(p), 2'd3), 0);
      end
      for (int i = 0; i < 8; i++) begin
         a = AW'(rand_next() >> 12);
         if (a[AW-1:6] == '0) begin
            a[6] = 1'b1;
         end
         do_read(a, 0);
      end
      report_test(3, "refused reads", err_start);

      err_start = errors;
      cp = IDX_W'(rand_next() >> 20);
      do_write(make_addr(cp, 2'd3), DW'(1), (DW/8)'(1), 0, 0, 0);
      read_all(1'b0);
      do_write(make_addr(cp + 1'b1, 2'd0), DW'(1), (DW/8)'(1), 0, 0, 0);
      do_write(make_addr(cp + 1'b1, 2'd3), DW'(2), (DW/8)'(1), 0, 0, 0);
      do_write(make_addr(cp + 1'b1, 2'd3), DW'(1), (DW/8)'(14), 0, 0, 0);
      do_write(make_addr(cp + 1'b1, 2'd3) | AW'(8'h40), DW'(1), (DW/8)'(1), 0, 0, 0);
      read_all(1'b0);
      // AW and W arriving in different cycles
      do_write(make_addr(cp + 2'd2, 2'd3), DW'(1), (DW/8)'(1), 3, 0, 0);
      do_write(make_addr(cp + 2'd3, 2'd3), DW'(1), (DW/8)'(1), 0, 2, 0);
      read_all(1'b0);
      report_test(4, "clear and refused writes", err_start);

      err_start = errors;
      fill_events(150);
      for (int i = 0; i < 8; i++) begin
         hold_a[i] = int'(rand_next() % 32'd8);
         addr_a[i] = make_addr(IDX_W'(rand_next() >> 20), 2'(rand_next() >> 24));
      end
      fork
         play_events();
         begin
            for (int i = 0; i < 8; i++) begin
               do_read(addr_a[i], hold_a[i]);
            end
            // Second request waits on AR while the first response stalls
            start_read(addr_a[0]);
            finish_read(hold_a[1], 1'b1, addr_a[2]);
            @(posedge ACLK);
            while (!ARREADY) @(posedge ACLK);
            finish_read(hold_a[3], 1'b0, '0);
            do_write(make_addr(addr_a[4][4 +: IDX_W], 2'd3), DW'(1), (DW/8)'(1), 0, 0, hold_a[4]);
            do_write(addr_a[5], DW'(1), (DW/8)'(1), 0, 1, hold_a[5]);
            do_write(make_addr(addr_a[6][4 +: IDX_W], 2'd3), DW'(1), (DW/8)'(1), 1, 0, hold_a[6]);
            do_write(make_addr(addr_a[7][4 +: IDX_W], 2'd0), DW'(1), (DW/8)'(1), 0, 0, hold_a[7]);
         end
      join
      repeat (2) @(negedge ACLK);
      read_all(1'b1);
      report_test(5, "back-pressure under traffic", err_start);

      repeat (4) @(negedge ACLK);
      left_over = (rd_exp_q.size() != 0) || (wr_exp_q.size() != 0);
      if (left_over) begin
         $display("Some bus transfers never received a response");
      end
      $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
      if ((errors == 0) && !left_over) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("=== FAIL ===");
      $finish;
   end

endmodule
